// File: bench/ptw_mem_model.sv
// Memory responder for the walker testbench that answers tagged reads out of order from sparse table memory
`default_nettype none
`timescale 1ns/1ps

module ptw_mem_model #(
	parameter int SEED = 32'he2
) (
	input logic clk,
	input logic rst,
	input logic hold,
	input logic req_valid,
	input bus_pkg::bus_adr_t req_adr,
	input bus_pkg::tranid_t req_tid,
	output logic req_ready,
	output logic resp_ack,
	output bus_pkg::tranid_t resp_tid,
	output bus_pkg::bus_dat_t resp_dat
);
	import bus_pkg::*;

	// ====================
	// Sparse memory
	// ====================

	// Only the words written by the testbench are stored, as address and data pairs
	bus_adr_t mem_adr [$];
	logic [31:0] mem_dat [$];

	// Reads waiting for their response, oldest at the front
	tranid_t pend_tid [$];
	bus_adr_t pend_adr [$];
	int pend_due [$];

	integer seed;
	int cyc;
	int pick;
	bus_adr_t base;

	// Store one 32-bit word, replacing an earlier value at the same address
	task automatic load_word(input bus_adr_t adr, input logic [31:0] dat);
		int idx;
		idx = -1;
		for (int i = 0; i < mem_adr.size(); i++)
			if (mem_adr[i] == adr)
				idx = i;
		if (idx < 0) begin
			mem_adr.push_back(adr);
			mem_dat.push_back(dat);
		end else begin
			mem_dat[idx] = dat;
		end
	endtask

	// Words never written return a pattern built from their whole address
	function automatic logic [31:0] read_word(input bus_adr_t adr);
		logic [31:0] dat;
		dat = ~adr ^ {adr[15:0], adr[31:16]};
		for (int i = 0; i < mem_adr.size(); i++)
			if (mem_adr[i] == adr)
				dat = mem_dat[i];
		return dat;
	endfunction

	initial begin
		seed = SEED;
		cyc = 0;
		req_ready = 1'b0;
		resp_ack = 1'b0;
		resp_tid = '0;
		resp_dat = '0;
	end

	// ====================
	// Responder
	// ====================

	always @(posedge clk) begin
		if (rst) begin
			cyc = 0;
			pend_tid.delete();
			pend_adr.delete();
			pend_due.delete();
			req_ready <= 1'b0;
			resp_ack <= 1'b0;
			resp_tid <= '0;
			resp_dat <= '0;
		end else begin
			cyc = cyc + 1;
			resp_ack <= 1'b0;
			// A read handed over at this edge becomes due a few cycles later
			if (req_valid && req_ready) begin
				pend_tid.push_back(req_tid);
				pend_adr.push_back(req_adr);
				pend_due.push_back(cyc + 1 + ($random(seed) & 7));
			end
			// Newest due read goes first, which reverses the order of a burst
			pick = -1;
			for (int i = 0; i < pend_tid.size(); i++)
				if (pend_due[i] <= cyc)
					pick = i;
			if (pick >= 0) begin
				base = {pend_adr[pick][31:4], 4'h0};
				resp_ack <= 1'b1;
				resp_tid <= pend_tid[pick];
				resp_dat <= {read_word(base + 32'd12), read_word(base + 32'd8),
					read_word(base + 32'd4), read_word(base)};
				pend_tid.delete(pick);
				pend_adr.delete(pick);
				pend_due.delete(pick);
			end
			// Request gaps, and a full stall while the testbench holds the bus
			req_ready <= !hold && (($random(seed) & 3) != 0);
		end
	end

endmodule

`default_nettype wire

// File: bench/ptw_tb.sv
// Testbench of the page table walker that runs a table of misses against an out-of-order memory
`default_nettype none
`timescale 1ns/1ps

module ptw_tb;
	import mmu_pkg::*;
	import bus_pkg::*;

	localparam int MISSQ_DEPTH = 4;
	localparam int NROWS = 12;
	localparam int CLK_PERIOD = 4;
	// Cycles with the bus stalled at the start, long enough for the miss queue to fill
	localparam int STALL_CYCLES = 20;
	localparam padr_t ROOT = 32'h0001_0000;

	logic clk;
	logic rst;
	logic miss_valid;
	vadr_t miss_vadr;
	asid_t miss_asid;
	logic miss_ready;
	padr_t root_base;
	logic req_valid;
	bus_adr_t req_adr;
	tranid_t req_tid;
	logic req_ready;
	logic resp_ack;
	tranid_t resp_tid;
	bus_dat_t resp_dat;
	logic result_valid;
	vadr_t result_vadr;
	asid_t result_asid;
	pte_t result_pte;
	logic result_fault;
	logic result_ready;
	logic hold_req;
	integer seed;

	// ====================
	// Stimulus table
	// ====================

	// One row per miss with both table entries and the expected result
	vadr_t row_vadr [NROWS];
	asid_t row_asid [NROWS];
	pte_t row_l1 [NROWS];
	pte_t row_l2 [NROWS];
	pte_t row_pte [NROWS];
	logic row_fault [NROWS];
	logic row_done [NROWS];
	logic row_l2_seen [NROWS];

	int n_rows;
	int done_cnt;
	int l1_idx;
	int accepted;
	logic wrapped;
	tranid_t last_tid;
	string end_problem;

	ptw_top #(
		.MISSQ_DEPTH(MISSQ_DEPTH)
	) uut (
		.clk(clk), .rst(rst),
		.miss_valid(miss_valid), .miss_vadr(miss_vadr), .miss_asid(miss_asid),
		.miss_ready(miss_ready), .root_base(root_base),
		.req_valid(req_valid), .req_adr(req_adr), .req_tid(req_tid), .req_ready(req_ready),
		.resp_ack(resp_ack), .resp_tid(resp_tid), .resp_dat(resp_dat),
		.result_valid(result_valid), .result_vadr(result_vadr), .result_asid(result_asid),
		.result_pte(result_pte), .result_fault(result_fault), .result_ready(result_ready)
	);

	ptw_mem_model #(
		.SEED(32'he2)
	) u_mem (
		.clk(clk), .rst(rst), .hold(hold_req),
		.req_valid(req_valid), .req_adr(req_adr), .req_tid(req_tid), .req_ready(req_ready),
		.resp_ack(resp_ack), .resp_tid(resp_tid), .resp_dat(resp_dat)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Table addresses follow the split of the virtual address, four bytes per entry
	function automatic padr_t l1_adr_of(input vadr_t va);
		return ROOT + {20'h0, va[31:22], 2'b00};
	endfunction

	function automatic padr_t l2_adr_of(input pte_t l1, input vadr_t va);
		return {l1[31:12], 12'h000} + {20'h0, va[21:12], 2'b00};
	endfunction

	task automatic add_row(input logic [9:0] vpn1, input logic [9:0] vpn0, input asid_t asid,
		input pte_t l1, input pte_t l2, input pte_t exp_pte, input logic exp_fault);
		row_vadr[n_rows] = {vpn1, vpn0, 12'(n_rows * 12'h111)};
		row_asid[n_rows] = asid;
		row_l1[n_rows] = l1;
		row_l2[n_rows] = l2;
		row_pte[n_rows] = exp_pte;
		row_fault[n_rows] = exp_fault;
		row_done[n_rows] = 1'b0;
		row_l2_seen[n_rows] = 1'b0;
		n_rows++;
	endtask

	// ====================
	// Checks
	// ====================

	task automatic check_pte(input string name, input pte_t exp, input pte_t act);
		if (act !== exp) begin
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_fault(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("FAILED at %0t ns: %s expected %b, got %b", $time, name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_adr(input string name, input bus_adr_t exp, input bus_adr_t act);
		if (act !== exp) begin
			$display("FAILED at %0t ns: %s expected %h, got %h", $time, name, exp, act);
			$display("TEST FAILED");
			$fatal(1);
		end
	endtask

	task automatic report_error(input string msg);
		$display("Error at %0t ns: %s", $time, msg);
		$display("TEST FAILED");
		$fatal(1);
	endtask

	// Level-1 reads come in miss order, level-2 reads must belong to a walk that needs one
	always @(posedge clk) begin : req_monitor
		int hit;
		if (!rst && req_valid && req_ready) begin
			if (req_tid == '0)
				report_error("read request carries transaction id zero");
			if (req_tid < last_tid)
				wrapped = 1'b1;
			last_tid = req_tid;
			if (req_adr >= ROOT && req_adr < ROOT + 32'h1000) begin
				if (l1_idx >= n_rows)
					report_error("more level-1 reads than misses");
				check_adr("req_adr", l1_adr_of(row_vadr[l1_idx]), req_adr);
				l1_idx++;
			end else begin
				hit = -1;
				for (int i = 0; i < n_rows; i++)
					if (hit < 0 && i < l1_idx && row_l1[i][0] && !row_l2_seen[i]
						&& l2_adr_of(row_l1[i], row_vadr[i]) == req_adr)
						hit = i;
				if (hit < 0)
					report_error($sformatf("level-2 read at %h that no walk needs", req_adr));
				row_l2_seen[hit] = 1'b1;
			end
		end
	end

	// Each result taken must close exactly one open row of the scoreboard
	always @(posedge clk) begin : scoreboard
		int hit;
		if (!rst && result_valid && result_ready) begin
			hit = -1;
			for (int i = 0; i < n_rows; i++)
				if (hit < 0 && !row_done[i] && row_vadr[i] == result_vadr
					&& row_asid[i] == result_asid)
					hit = i;
			if (hit < 0)
				report_error($sformatf("result for vadr %h asid %h matches no open miss",
					result_vadr, result_asid));
			if (row_l1[hit][0] && !row_l2_seen[hit])
				report_error("result came out before its level-2 read was issued");
			check_pte("result_pte", row_pte[hit], result_pte);
			check_fault("result_fault", row_fault[hit], result_fault);
			row_done[hit] = 1'b1;
			done_cnt++;
		end
	end

	always @(posedge clk)
		result_ready <= !rst && (($random(seed) & 3) != 0);

	// ====================
	// Stimulus
	// ====================

	task automatic send_misses();
		for (int i = 0; i < n_rows; i++) begin
			miss_valid <= 1'b1;
			miss_vadr <= row_vadr[i];
			miss_asid <= row_asid[i];
			@(posedge clk);
			while (!miss_ready)
				@(posedge clk);
			accepted++;
		end
		miss_valid <= 1'b0;
	endtask

	// While the bus is stalled only one walk starts, so the queue fills behind it
	task automatic release_requests();
		repeat (STALL_CYCLES) @(posedge clk);
		if (accepted != MISSQ_DEPTH + 1)
			report_error($sformatf("%0d misses taken with the bus stalled", accepted));
		if (miss_ready)
			report_error("miss_ready stayed high with the miss queue full");
		hold_req <= 1'b0;
	endtask

	initial begin
		seed = 32'he2;
		rst = 1'b1;
		miss_valid = 1'b0;
		miss_vadr = '0;
		miss_asid = '0;
		root_base = ROOT;
		result_ready = 1'b0;
		hold_req = 1'b1;
		n_rows = 0;
		done_cnt = 0;
		l1_idx = 0;
		accepted = 0;
		wrapped = 1'b0;
		last_tid = '0;
		end_problem = "";
		// Rows 0 to 3 share one level-1 word and put their level-2 entries in lanes 0 to 3
		add_row(10'h000, 10'h000, 8'h01, 32'h0002_0001, 32'h1000_0001, 32'h1000_0001, 1'b0);
		add_row(10'h001, 10'h005, 8'h02, 32'h0002_1001, 32'h1111_1003, 32'h1111_1003, 1'b0);
		add_row(10'h002, 10'h00a, 8'h03, 32'h0002_2001, 32'h1222_2005, 32'h1222_2005, 1'b0);
		add_row(10'h003, 10'h00f, 8'h04, 32'h0002_3001, 32'h1333_3007, 32'h1333_3007, 1'b0);
		// Level-1 fault
		add_row(10'h010, 10'h100, 8'h05, 32'h0003_3000, 32'h0000_0000, 32'h0003_3000, 1'b1);
		// Level-2 fault
		add_row(10'h011, 10'h3ff, 8'h06, 32'h0002_5001, 32'h1555_5000, 32'h1555_5000, 1'b1);
		add_row(10'h105, 10'h201, 8'h07, 32'h0002_6001, 32'h1666_6001, 32'h1666_6001, 1'b0);
		add_row(10'h106, 10'h202, 8'h08, 32'h0002_7001, 32'h1777_7003, 32'h1777_7003, 1'b0);
		// Same page as row 6 under another asid
		add_row(10'h105, 10'h201, 8'h09, 32'h0002_6001, 32'h1666_6001, 32'h1666_6001, 1'b0);
		add_row(10'h2f0, 10'h0c3, 8'h0a, 32'h0004_9ffe, 32'h0000_0000, 32'h0004_9ffe, 1'b1);
		add_row(10'h3fe, 10'h044, 8'h0b, 32'h0002_a001, 32'h1aaa_a00f, 32'h1aaa_a00f, 1'b0);
		add_row(10'h3ff, 10'h387, 8'h0c, 32'h0002_b001, 32'h1bbb_b001, 32'h1bbb_b001, 1'b0);
		for (int i = 0; i < n_rows; i++) begin
			u_mem.load_word(l1_adr_of(row_vadr[i]), row_l1[i]);
			if (row_l1[i][0])
				u_mem.load_word(l2_adr_of(row_l1[i], row_vadr[i]), row_l2[i]);
		end
		repeat (4) @(posedge clk);
		rst <= 1'b0;
		fork
			send_misses();
			release_requests();
		join
		while (done_cnt < n_rows)
			@(posedge clk);
		if (l1_idx != n_rows)
			end_problem = "level-1 reads do not match the number of misses";
		for (int i = 0; i < n_rows; i++)
			if (row_l1[i][0] && !row_l2_seen[i])
				end_problem = "a walk finished without its level-2 read";
		if (!wrapped)
			end_problem = "transaction ids never wrapped";
		if (end_problem != "") begin
			report_error(end_problem);
		end else begin
			$display("TEST PASSED");
			$finish;
		end
	end

	// Watchdog
	initial begin
		#(NROWS * 200 * CLK_PERIOD);
		report_error($sformatf("run timed out with %0d of %0d results missing",
			NROWS - done_cnt, NROWS));
	end

endmodule

`default_nettype wire

// File: design/bus_pkg.sv
// Types and constants of the tagged split-transaction read bus, imported by the walker RTL
`default_nettype none

package bus_pkg;

	// Transaction id carried by every read. Zero never names a live read
	typedef logic [3:0] tranid_t;

	// Byte address of a read request
	typedef logic [31:0] bus_adr_t;

	// Response word of four 32-bit lanes
	typedef logic [127:0] bus_dat_t;

	// Number of slots addressed by a transaction id, slot zero included
	parameter int NUM_TRAN = 16;

	// The id counter starts here after reset and comes back here after the last id
	parameter tranid_t TRANID_FIRST = 4'd1;
	parameter tranid_t TRANID_LAST = 4'd15;

	// Lane geometry of the response word.
	// Address bits 3..2 pick one 32-bit lane out of the 128-bit word
	parameter int LANE_W = 32;
	parameter int LANE_SEL_HI = 3;
	parameter int LANE_SEL_LO = 2;

endpackage

`default_nettype wire

// File: design/mmu_pkg.sv
// Address, asid and page table entry types plus the virtual address split, imported by the walker RTL
`default_nettype none

package mmu_pkg;

	// ====================
	// Basic widths
	// ====================

	// Virtual address as it arrives with a TLB miss
	typedef logic [31:0] vadr_t;

	// Physical address of a table entry or a page frame
	typedef logic [31:0] padr_t;

	// Address space id that travels with each walk
	typedef logic [7:0] asid_t;

	// Page table entry. Bit 0 is valid, bits 31..12 hold the page frame number
	typedef logic [31:0] pte_t;

	// One virtual page number field, used to index either table
	typedef logic [9:0] vpn_t;

	// Which table an outstanding read targets
	typedef enum logic {
		LVL1,
		LVL2
	} walk_lvl_t;

	// ====================
	// Table geometry
	// ====================

	// Every entry is four bytes, so an index is scaled by four
	parameter int unsigned PTE_BYTES = 4;

	// Level-1 index field of the virtual address
	parameter int VPN1_HI = 31;
	parameter int VPN1_LO = 22;

	// Level-2 index field of the virtual address
	parameter int VPN0_HI = 21;
	parameter int VPN0_LO = 12;

	// Frame number field of an entry; the low bits are the page offset
	parameter int PFN_HI = 31;
	parameter int PFN_LO = 12;
	parameter int PTE_V_BIT = 0;

endpackage

`default_nettype wire

// File: design/ptw_ifs.sv
// Interfaces between the miss queue, the transaction buffer and the walk engine
`default_nettype none
`timescale 1ns/1ps

// ====================
// Miss queue to walker
// ====================

// The head of the miss queue as seen by the walker.
// An entry leaves the queue in a cycle where valid and take are both high
interface miss_if;
	import mmu_pkg::*;

	logic valid;
	vadr_t vadr;
	asid_t asid;
	logic take;

	modport queue (output valid, vadr, asid, input take);
	modport walker (input valid, vadr, asid, output take);
endinterface

// ====================
// Walker to buffer
// ====================

// Allocation, selection and release of outstanding reads.
// The walker only raises alloc while can_alloc is high
interface tran_if;
	import mmu_pkg::*;
	import bus_pkg::*;

	// New outstanding read, written at next_tid
	logic alloc;
	vadr_t alloc_vadr;
	asid_t alloc_asid;
	padr_t alloc_padr;
	walk_lvl_t alloc_lvl;
	logic can_alloc;
	tranid_t next_tid;

	// Ready flags of all slots and the contents of the slot picked by sel_tid
	logic [NUM_TRAN-1:0] rdy_vec;
	logic sel;
	tranid_t sel_tid;
	vadr_t sel_vadr;
	asid_t sel_asid;
	walk_lvl_t sel_lvl;
	pte_t sel_pte;

	modport walker (
		output alloc, alloc_vadr, alloc_asid, alloc_padr, alloc_lvl, sel, sel_tid,
		input can_alloc, next_tid, rdy_vec, sel_vadr, sel_asid, sel_lvl, sel_pte
	);
	modport buffer (
		input alloc, alloc_vadr, alloc_asid, alloc_padr, alloc_lvl, sel, sel_tid,
		output can_alloc, next_tid, rdy_vec, sel_vadr, sel_asid, sel_lvl, sel_pte
	);
endinterface

`default_nettype wire

// File: design/ptw_miss_queue.sv
// Circular FIFO that holds incoming TLB misses until the walker starts their table walk
`default_nettype none
`timescale 1ns/1ps

module ptw_miss_queue #(
	parameter int MISSQ_DEPTH = 4
) (
	input logic clk,
	input logic rst,
	input logic miss_valid,
	input mmu_pkg::vadr_t miss_vadr,
	input mmu_pkg::asid_t miss_asid,
	output logic miss_ready,
	miss_if.queue mq
);
	import mmu_pkg::*;

	// The depth is a power of two, so the pointers wrap on their own
	localparam int PTR_W = $clog2(MISSQ_DEPTH);

	vadr_t vadr_mem [MISSQ_DEPTH];
	asid_t asid_mem [MISSQ_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	// One bit wider than the pointers so that full and empty differ
	logic [PTR_W:0] count;

	logic push;
	logic pop;

	// A full queue refuses new misses even if the head leaves this cycle
	assign miss_ready = (count != (PTR_W + 1)'(MISSQ_DEPTH));
	assign push = miss_valid && miss_ready;
	assign pop = mq.valid && mq.take;

	// The head is offered to the walker straight from storage
	assign mq.valid = (count != '0);
	assign mq.vadr = vadr_mem[rd_ptr];
	assign mq.asid = asid_mem[rd_ptr];

	// Pointers and fill level
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// Push and pop together leave the fill level alone
			if (push && !pop)
				count <= count + 1'b1;
			else if (pop && !push)
				count <= count - 1'b1;
		end
	end

	// Miss storage
	always_ff @(posedge clk) begin
		if (push) begin
			vadr_mem[wr_ptr] <= miss_vadr;
			asid_mem[wr_ptr] <= miss_asid;
		end
	end

	// The fill level stays within the storage over any run of pushes and pops
	a_count_bound: assert property (@(posedge clk) disable iff (rst)
		count <= (PTR_W + 1)'(MISSQ_DEPTH));

endmodule

`default_nettype wire

// File: design/ptw_top.sv
// Top level of the page table walker, joining miss queue, transaction buffer and walk engine on plain ports
`default_nettype none
`timescale 1ns/1ps

module ptw_top #(
	parameter int MISSQ_DEPTH = 4
) (
	input logic clk,
	input logic rst,

	// TLB miss input
	input logic miss_valid,
	input mmu_pkg::vadr_t miss_vadr,
	input mmu_pkg::asid_t miss_asid,
	output logic miss_ready,

	// Level-1 table base, stable during a run
	input mmu_pkg::padr_t root_base,

	// Tagged read request
	output logic req_valid,
	output bus_pkg::bus_adr_t req_adr,
	output bus_pkg::tranid_t req_tid,
	input logic req_ready,

	// Tagged read response, a single-cycle pulse
	input logic resp_ack,
	input bus_pkg::tranid_t resp_tid,
	input bus_pkg::bus_dat_t resp_dat,

	// Walk result
	output logic result_valid,
	output mmu_pkg::vadr_t result_vadr,
	output mmu_pkg::asid_t result_asid,
	output mmu_pkg::pte_t result_pte,
	output logic result_fault,
	input logic result_ready
);

	miss_if miss_ch ();
	tran_if tran_ch ();

	// Misses wait here until the walker has a free id
	ptw_miss_queue #(
		.MISSQ_DEPTH(MISSQ_DEPTH)
	) u_miss_queue (
		.clk(clk),
		.rst(rst),
		.miss_valid(miss_valid),
		.miss_vadr(miss_vadr),
		.miss_asid(miss_asid),
		.miss_ready(miss_ready),
		.mq(miss_ch.queue)
	);

	// Outstanding reads and their responses
	ptw_tran_buffer u_tran_buffer (
		.clk(clk),
		.rst(rst),
		.resp_ack(resp_ack),
		.resp_tid(resp_tid),
		.resp_dat(resp_dat),
		.tb(tran_ch.buffer)
	);

	ptw_walker u_walker (
		.clk(clk),
		.rst(rst),
		.root_base(root_base),
		.mq(miss_ch.walker),
		.tb(tran_ch.walker),
		.req_valid(req_valid),
		.req_adr(req_adr),
		.req_tid(req_tid),
		.req_ready(req_ready),
		.result_valid(result_valid),
		.result_vadr(result_vadr),
		.result_asid(result_asid),
		.result_pte(result_pte),
		.result_fault(result_fault),
		.result_ready(result_ready)
	);

endmodule

`default_nettype wire

// File: design/ptw_tran_buffer.sv
// Buffer of outstanding table reads indexed by transaction id, filled in by tagged responses
`default_nettype none
`timescale 1ns/1ps

module ptw_tran_buffer (
	input logic clk,
	input logic rst,
	input logic resp_ack,
	input bus_pkg::tranid_t resp_tid,
	input bus_pkg::bus_dat_t resp_dat,
	tran_if.buffer tb
);
	import mmu_pkg::*;
	import bus_pkg::*;

	// ====================
	// Slot state
	// ====================

	// Control flags per slot. Slot zero is never allocated
	logic [NUM_TRAN-1:0] v;
	logic [NUM_TRAN-1:0] rdy;

	// Payload per slot
	vadr_t vadr_mem [NUM_TRAN];
	asid_t asid_mem [NUM_TRAN];
	padr_t padr_mem [NUM_TRAN];
	walk_lvl_t lvl_mem [NUM_TRAN];
	pte_t pte_mem [NUM_TRAN];

	// Id that the next allocation receives
	tranid_t cnt;
	tranid_t cnt_next;

	logic resp_hit;
	logic [LANE_SEL_HI-LANE_SEL_LO:0] resp_lane;

	// The counter runs 1 to 15 and then starts over at 1, so zero never comes out
	assign cnt_next = (cnt == TRANID_LAST) ? TRANID_FIRST : cnt + 1'b1;

	assign tb.next_tid = cnt;
	assign tb.can_alloc = !v[cnt];
	assign tb.rdy_vec = v & rdy;

	// Read port for the slot the walker is looking at
	assign tb.sel_vadr = vadr_mem[tb.sel_tid];
	assign tb.sel_asid = asid_mem[tb.sel_tid];
	assign tb.sel_lvl = lvl_mem[tb.sel_tid];
	assign tb.sel_pte = pte_mem[tb.sel_tid];

	// A response counts only with a non-zero id that names a live read still waiting
	assign resp_hit = resp_ack && (resp_tid != '0) && v[resp_tid] && !rdy[resp_tid];

	// The entry sits in the lane picked by the read address of that slot
	assign resp_lane = padr_mem[resp_tid][LANE_SEL_HI:LANE_SEL_LO];

	// ====================
	// Control
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			v <= '0;
			rdy <= '0;
			cnt <= TRANID_FIRST;
		end else begin
			if (resp_hit)
				rdy[resp_tid] <= 1'b1;
			// Release the slot the walker is done with
			if (tb.sel) begin
				v[tb.sel_tid] <= 1'b0;
				rdy[tb.sel_tid] <= 1'b0;
			end
			if (tb.alloc) begin
				v[cnt] <= 1'b1;
				rdy[cnt] <= 1'b0;
			end
			// Step past a busy slot as well, so a free id comes round again
			if (tb.alloc || v[cnt])
				cnt <= cnt_next;
		end
	end

	// Payload capture on allocation and on response
	always_ff @(posedge clk) begin
		if (tb.alloc) begin
			vadr_mem[cnt] <= tb.alloc_vadr;
			asid_mem[cnt] <= tb.alloc_asid;
			padr_mem[cnt] <= tb.alloc_padr;
			lvl_mem[cnt] <= tb.alloc_lvl;
		end
		if (resp_hit)
			pte_mem[resp_tid] <= resp_dat[resp_lane*LANE_W +: LANE_W];
	end

	// ====================
	// Protocol checks
	// ====================

	// Every response answers a read that is still outstanding
	a_resp_live: assert property (@(posedge clk) disable iff (rst)
		resp_ack |-> (resp_tid != '0) && v[resp_tid] && !rdy[resp_tid]);

endmodule

`default_nettype wire

// File: design/ptw_walker.sv
// Walk engine that starts level-1 reads, turns finished level-1 reads into level-2 reads and delivers results
`default_nettype none
`timescale 1ns/1ps

module ptw_walker (
	input logic clk,
	input logic rst,
	input mmu_pkg::padr_t root_base,
	miss_if.walker mq,
	tran_if.walker tb,
	output logic req_valid,
	output bus_pkg::bus_adr_t req_adr,
	output bus_pkg::tranid_t req_tid,
	input logic req_ready,
	output logic result_valid,
	output mmu_pkg::vadr_t result_vadr,
	output mmu_pkg::asid_t result_asid,
	output mmu_pkg::pte_t result_pte,
	output logic result_fault,
	input logic result_ready
);
	import mmu_pkg::*;
	import bus_pkg::*;

	// Two slots are kept out of reach of new walks so a level-1 read can always move on
	localparam int MAX_WALKS = NUM_TRAN - 2;

	logic [$clog2(NUM_TRAN)-1:0] walks;

	logic sel_hit;
	tranid_t sel_pick;
	logic sel_cont;
	logic req_free;
	logic res_free;
	logic do_cont;
	logic do_fin;
	logic do_new;

	vpn_t vpn1;
	vpn_t vpn0;
	padr_t l1_adr;
	padr_t l2_adr;

	// ====================
	// Slot selection
	// ====================

	// Lowest-numbered ready slot wins
	always_comb begin
		sel_hit = 1'b0;
		sel_pick = '0;
		for (int i = NUM_TRAN - 1; i > 0; i--) begin
			if (tb.rdy_vec[i]) begin
				sel_hit = 1'b1;
				sel_pick = tranid_t'(i);
			end
		end
	end

	// A valid level-1 entry continues the walk, anything else finishes it
	assign sel_cont = (tb.sel_lvl == LVL1) && tb.sel_pte[PTE_V_BIT];

	// Output registers that are empty or draining this cycle can be loaded
	assign req_free = !req_valid || req_ready;
	assign res_free = !result_valid || result_ready;

	assign do_cont = sel_hit && sel_cont && req_free && tb.can_alloc;
	assign do_fin = sel_hit && !sel_cont && res_free;
	// A new walk yields to a pending continuation
	assign do_new = mq.valid && req_free && tb.can_alloc && !(sel_hit && sel_cont)
		&& (walks < MAX_WALKS);

	// Table addresses of both levels
	assign vpn1 = mq.vadr[VPN1_HI:VPN1_LO];
	assign vpn0 = tb.sel_vadr[VPN0_HI:VPN0_LO];
	assign l1_adr = root_base + padr_t'(padr_t'(vpn1) * PTE_BYTES);
	assign l2_adr = {tb.sel_pte[PFN_HI:PFN_LO], {PFN_LO{1'b0}}}
		+ padr_t'(padr_t'(vpn0) * PTE_BYTES);

	// ====================
	// Buffer and queue control
	// ====================

	assign mq.take = do_new;
	assign tb.sel = do_cont || do_fin;
	assign tb.sel_tid = sel_pick;
	assign tb.alloc = do_cont || do_new;
	assign tb.alloc_vadr = do_cont ? tb.sel_vadr : mq.vadr;
	assign tb.alloc_asid = do_cont ? tb.sel_asid : mq.asid;
	assign tb.alloc_padr = do_cont ? l2_adr : l1_adr;
	assign tb.alloc_lvl = do_cont ? LVL2 : LVL1;

	// Walks in flight, each holding exactly one slot
	always_ff @(posedge clk) begin
		if (rst)
			walks <= '0;
		else if (do_new && !do_fin)
			walks <= walks + 1'b1;
		else if (do_fin && !do_new)
			walks <= walks - 1'b1;
	end

	// ====================
	// Output registers
	// ====================

	// Read request, held until the bus takes it
	always_ff @(posedge clk) begin
		if (rst) begin
			req_valid <= 1'b0;
		end else if (tb.alloc) begin
			req_valid <= 1'b1;
		end else if (req_ready) begin
			req_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (tb.alloc) begin
			req_adr <= tb.alloc_padr;
			req_tid <= tb.next_tid;
		end
	end

	// Result, held until the consumer takes it
	always_ff @(posedge clk) begin
		if (rst)
			result_valid <= 1'b0;
		else if (do_fin)
			result_valid <= 1'b1;
		else if (result_ready)
			result_valid <= 1'b0;
	end

	always_ff @(posedge clk) begin
		if (do_fin) begin
			result_vadr <= tb.sel_vadr;
			result_asid <= tb.sel_asid;
			result_pte <= tb.sel_pte;
			result_fault <= !tb.sel_pte[PTE_V_BIT];
		end
	end

	// A stalled request keeps its address and id until it is taken
	a_req_hold: assert property (@(posedge clk) disable iff (rst)
		req_valid && !req_ready |=> req_valid && $stable(req_adr) && $stable(req_tid));

endmodule

`default_nettype wire

// File: ptw.f
design/mmu_pkg.sv
design/bus_pkg.sv
design/ptw_ifs.sv
design/ptw_miss_queue.sv
design/ptw_tran_buffer.sv
design/ptw_walker.sv
design/ptw_top.sv
bench/ptw_mem_model.sv
bench/ptw_tb.sv
